// ==== logic/xfer_crossbar.sv ====
`default_nettype none

module xfer_crossbar (
  input  wire                                                  CLK,
  input  wire                                                  arst_n,
  input  wire [xfer_pkg::num_regs-1:0]                         isel_a,
  input  wire [xfer_pkg::num_regs-1:0]                         isel_b,
  input  wire                                                  lit_sel,
  input  wire [xfer_pkg::word_w-1:0]                           lit_value,
  input  wire [xfer_pkg::num_regs-1:0]                         dst_lane,
  input  wire [xfer_pkg::num_regs-1:0][xfer_pkg::word_w-1:0]   regs,
  output logic [xfer_pkg::num_regs-1:0][xfer_pkg::word_w-1:0]  wr_data
);
  import xfer_pkg::*;

  logic [word_w-1:0] src_a;
  logic [word_w-1:0] src_b;
  logic [word_w-1:0] fan_a;
  logic [word_w-1:0] fan_b;

  // AND-OR gather of the sources, a plain mux as long as the selects stay one-hot
  always_comb
  begin
    src_a = '0;
    src_b = '0;
    for (int i = 0; i < num_regs; i++)
    begin
      src_a = src_a | ({word_w{isel_a[i]}} & regs[i]);
      src_b = src_b | ({word_w{isel_b[i]}} & regs[i]);
    end
  end

  // both lanes latch on the same edge, so a swap reads the old values of both registers
  always_ff @(posedge CLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      fan_a <= '0;
      fan_b <= '0;
    end
    else
    begin
      fan_a <= src_a;
      if (lit_sel)
        fan_b <= lit_value;
      else
        fan_b <= src_b;
    end
  end

  always_comb
  begin
    for (int i = 0; i < num_regs; i++)
    begin
      if (dst_lane[i] == lane_a_sel)
        wr_data[i] = fan_a;
      else
        wr_data[i] = fan_b;
    end
  end

  // the decoder must never hand over more than one source per lane
  assert property (@(posedge CLK) disable iff (!arst_n) $onehot0(isel_a));

  assert property (@(posedge CLK) disable iff (!arst_n) $onehot0(isel_b));

  // lane b carries either a register or the literal, never both in one stage
  assert property (@(posedge CLK) disable iff (!arst_n) !(lit_sel && (|isel_b)));

endmodule

`default_nettype wire

// ==== logic/xfer_decoder.sv ====
`default_nettype none

module xfer_decoder (
  input  wire                           CLK,
  input  wire                           arst_n,
  input  wire                           op_strobe,
  input  wire xfer_pkg::micro_word_u    op_word,
  output logic [xfer_pkg::num_regs-1:0] isel_a,
  output logic [xfer_pkg::num_regs-1:0] isel_b,
  output logic                          lit_sel,
  output logic [xfer_pkg::word_w-1:0]   lit_value,
  output logic [xfer_pkg::num_regs-1:0] dst_en,
  output logic [xfer_pkg::num_regs-1:0] dst_lane
);
  import xfer_pkg::*;

  logic [num_regs-1:0] pend_en;
  logic [num_regs-1:0] pend_lane;
  logic                is_lit;

  function automatic logic [num_regs-1:0] idx_to_onehot(input logic [reg_idx_w-1:0] idx);
    logic [num_regs-1:0] vec;
    vec      = '0;
    vec[idx] = 1'b1;
    return vec;
  endfunction

  assign is_lit = (op_word.move.kind == kind_lit);

  // stage 1 drives the fan lanes, stage 2 holds the destinations until the lanes are loaded
  always_ff @(posedge CLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      isel_a    <= '0;
      isel_b    <= '0;
      lit_sel   <= 1'b0;
      pend_en   <= '0;
      pend_lane <= '0;
      dst_en    <= '0;
      dst_lane  <= '0;
    end
    else
    begin
      isel_a    <= '0;
      isel_b    <= '0;
      lit_sel   <= 1'b0;
      pend_en   <= '0;
      pend_lane <= '0;
      if (op_strobe)
      begin
        if (is_lit)
        begin
          lit_sel   <= 1'b1;
          pend_en   <= idx_to_onehot(op_word.lit.dst);
          // the literal always travels on lane b
          pend_lane <= {num_regs{~lane_a_sel}};
        end
        else
        begin
          isel_a <= idx_to_onehot(op_word.move.src_a);
          if (op_word.move.dual)
            isel_b <= idx_to_onehot(op_word.move.src_b);
          pend_en   <= op_word.move.dst_en;
          pend_lane <= op_word.move.dst_lane;
        end
      end
      dst_en   <= pend_en;
      dst_lane <= pend_lane;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (op_strobe && is_lit)
      lit_value <= {{(word_w-lit_w){1'b0}}, op_word.lit.value};
  end

  // a single-lane move must land every enabled destination on lane a two edges later
  property single_lane_dst_on_a;
    @(posedge CLK) disable iff (!arst_n)
      (op_strobe && op_word.move.kind == kind_move && !op_word.move.dual)
        |-> ##2 ((dst_en & (dst_lane ^ {num_regs{lane_a_sel}})) == '0);
  endproperty

  assert property (single_lane_dst_on_a);

endmodule

`default_nettype wire

// ==== logic/xfer_pkg.sv ====
`default_nettype none

package xfer_pkg;

  // eight registers, which are also the eight crossbar ports
  localparam int num_regs  = 8;
  localparam int reg_idx_w = 3;
  localparam int word_w    = 32;
  localparam int lit_w     = 28;

  // the kind bit is the top bit in both views of a micro word
  localparam logic kind_move = 1'b0;
  localparam logic kind_lit  = 1'b1;

  // a dst_lane bit equal to this picks lane a, the other value picks lane b
  localparam logic lane_a_sel = 1'b1;

  typedef struct packed {
    logic                 kind;
    logic                 dual;
    logic [reg_idx_w-1:0] src_a;
    logic [reg_idx_w-1:0] src_b;
    logic [num_regs-1:0]  dst_en;
    logic [num_regs-1:0]  dst_lane;
    logic [7:0]           reserved;
  } xfer_move_t;

  typedef struct packed {
    logic                 kind;
    logic [reg_idx_w-1:0] dst;
    logic [lit_w-1:0]     value;
  } xfer_lit_t;

  // one 32-bit micro word seen either as a move or as a literal
  typedef union packed {
    xfer_move_t move;
    xfer_lit_t  lit;
  } micro_word_u;

endpackage

`default_nettype wire

// ==== logic/xfer_regfile.sv ====
`default_nettype none

module xfer_regfile (
  input  wire                                                  CLK,
  input  wire                                                  arst_n,
  input  wire [xfer_pkg::num_regs-1:0]                         dst_en,
  input  wire [xfer_pkg::num_regs-1:0][xfer_pkg::word_w-1:0]   wr_data,
  input  wire                                                  load_strobe,
  input  wire [xfer_pkg::reg_idx_w-1:0]                        load_addr,
  input  wire [xfer_pkg::word_w-1:0]                           load_data,
  input  wire [xfer_pkg::reg_idx_w-1:0]                        rd_addr,
  output logic [xfer_pkg::word_w-1:0]                          rd_data,
  output logic [xfer_pkg::num_regs-1:0][xfer_pkg::word_w-1:0]  regs
);
  import xfer_pkg::*;

  always_ff @(posedge CLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      regs <= '0;
    end
    else
    begin
      for (int i = 0; i < num_regs; i++)
      begin
        // a crossbar write to the same register beats an external load
        if (dst_en[i])
          regs[i] <= wr_data[i];
        else if (load_strobe && load_addr == reg_idx_w'(i))
          regs[i] <= load_data;
      end
    end
  end

  assign rd_data = regs[rd_addr];

endmodule

`default_nettype wire

// ==== logic/xfer_top.sv ====
`default_nettype none

module xfer_top (
  input  wire                            CLK,
  input  wire                            arst_n,
  input  wire                            op_strobe,
  input  wire xfer_pkg::micro_word_u     op_word,
  input  wire                            load_strobe,
  input  wire [xfer_pkg::reg_idx_w-1:0]  load_addr,
  input  wire [xfer_pkg::word_w-1:0]     load_data,
  input  wire [xfer_pkg::reg_idx_w-1:0]  rd_addr,
  output wire [xfer_pkg::word_w-1:0]     rd_data
);
  import xfer_pkg::*;

  wire [num_regs-1:0]             isel_a;
  wire [num_regs-1:0]             isel_b;
  wire                            lit_sel;
  wire [word_w-1:0]               lit_value;
  wire [num_regs-1:0]             dst_en;
  wire [num_regs-1:0]             dst_lane;
  wire [num_regs-1:0][word_w-1:0] wr_data;
  wire [num_regs-1:0][word_w-1:0] regs;

  xfer_decoder u_decoder (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .op_strobe (op_strobe),
    .op_word   (op_word),
    .isel_a    (isel_a),
    .isel_b    (isel_b),
    .lit_sel   (lit_sel),
    .lit_value (lit_value),
    .dst_en    (dst_en),
    .dst_lane  (dst_lane)
  );

  // the register values feed back as crossbar sources
  xfer_crossbar u_crossbar (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .isel_a    (isel_a),
    .isel_b    (isel_b),
    .lit_sel   (lit_sel),
    .lit_value (lit_value),
    .dst_lane  (dst_lane),
    .regs      (regs),
    .wr_data   (wr_data)
  );

  xfer_regfile u_regfile (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .dst_en      (dst_en),
    .wr_data     (wr_data),
    .load_strobe (load_strobe),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .regs        (regs)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the xfer testbench with Verilator; exit status 1 on failure.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module xfer_tb -f verilog.f \
  --Mdir obj_dir -o xfer_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/xfer_sim > sim.log 2>&1

grep -q "^NO ERRORS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// ==== verif/xfer_tb.sv ====
`default_nettype none

module xfer_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import xfer_pkg::*;

  // the tests take about 120 cycles, so 400 leaves plenty of room
  localparam int max_cycles = 400;

  logic                 CLK;
  logic                 arst_n;
  logic                 op_strobe;
  micro_word_u          op_word;
  logic                 load_strobe;
  logic [reg_idx_w-1:0] load_addr;
  logic [word_w-1:0]    load_data;
  logic [reg_idx_w-1:0] rd_addr;
  wire  [word_w-1:0]    rd_data;

  logic [word_w-1:0] model [num_regs];
  logic [31:0]       lcg_state;
  int                errors = 0;
  int                checks = 0;
  int                cycles = 0;

  xfer_top dut (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .op_strobe   (op_strobe),
    .op_word     (op_word),
    .load_strobe (load_strobe),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data)
  );

  always #50 CLK = ~CLK;

  always @(posedge CLK)
  begin
    cycles = cycles + 1;
    if (cycles >= max_cycles)
    begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic micro_word_u make_move(input logic dual, input logic [2:0] src_a,
                                            input logic [2:0] src_b, input logic [7:0] en,
                                            input logic [7:0] lane);
    micro_word_u w;
    w                = '0;
    w.move.kind      = 1'b0;
    w.move.dual      = dual;
    w.move.src_a     = src_a;
    w.move.src_b     = src_b;
    w.move.dst_en    = en;
    w.move.dst_lane  = lane;
    return w;
  endfunction

  function automatic micro_word_u make_literal(input logic [2:0] dst, input logic [27:0] value);
    micro_word_u w;
    w           = '0;
    w.lit.kind  = 1'b1;
    w.lit.dst   = dst;
    w.lit.value = value;
    return w;
  endfunction

  // both lanes take the register values from before the write
  task automatic model_move(input logic dual, input logic [2:0] src_a, input logic [2:0] src_b,
                            input logic [7:0] en, input logic [7:0] lane);
    logic [word_w-1:0] lane_a;
    logic [word_w-1:0] lane_b;
    lane_a = model[src_a];
    lane_b = dual ? model[src_b] : '0;
    for (int i = 0; i < num_regs; i++)
    begin
      if (en[i])
        model[i] = (lane[i] == lane_a_sel) ? lane_a : lane_b;
    end
  endtask

  // called at a falling edge, so rd_data settles well before the next rising edge
  task automatic read_check(input int idx, input logic [word_w-1:0] expected);
    rd_addr = idx[reg_idx_w-1:0];
    #10;
    checks = checks + 1;
    assert (rd_data === expected)
    else
    begin
      errors = errors + 1;
      $display("FAILED rd_data (r%0d) expected 0x%08h actual 0x%08h", idx, expected, rd_data);
    end
  endtask

  task automatic check_all();
    for (int i = 0; i < num_regs; i++)
    begin
      @(negedge CLK);
      read_check(i, model[i]);
    end
  endtask

  task automatic send_op(input micro_word_u w);
    @(negedge CLK);
    op_strobe = 1'b1;
    op_word   = w;
    @(negedge CLK);
    op_strobe = 1'b0;
    op_word   = '0;
  endtask

  task automatic run_move(input logic dual, input logic [2:0] src_a, input logic [2:0] src_b,
                          input logic [7:0] en, input logic [7:0] lane);
    send_op(make_move(dual, src_a, src_b, en, lane));
    // decoded at E0, lanes latch at E1, destinations written at E2
    repeat (2) @(negedge CLK);
    model_move(dual, src_a, src_b, en, lane);
    check_all();
  endtask

  task automatic test_reset_values();
    for (int i = 0; i < num_regs; i++)
      model[i] = '0;
    check_all();
  endtask

  task automatic test_loads();
    logic [word_w-1:0] value;
    for (int i = 0; i < num_regs; i++)
    begin
      value = lcg_next();
      @(negedge CLK);
      load_strobe = 1'b1;
      load_addr   = i[reg_idx_w-1:0];
      load_data   = value;
      @(negedge CLK);
      load_strobe = 1'b0;
      model[i]    = value;
      read_check(i, value);
    end
  endtask

  task automatic test_single_lane_fanout();
    run_move(1'b0, 3'd2, 3'd0, 8'b1010_0010, 8'b1010_0010);
  endtask

  task automatic test_dual_swap();
    // r3 takes lane a from r0, r0 takes lane b from r3
    run_move(1'b1, 3'd0, 3'd3, 8'b0000_1001, 8'b0000_1000);
  endtask

  task automatic test_literal();
    logic [lit_w-1:0] value;
    value = lit_w'(lcg_next());
    value[lit_w-1] = 1'b1;
    send_op(make_literal(3'd6, value));
    repeat (2) @(negedge CLK);
    model[6] = {{(word_w-lit_w){1'b0}}, value};
    check_all();
  endtask

  task automatic test_back_to_back();
    @(negedge CLK);
    op_strobe = 1'b1;
    op_word   = make_move(1'b0, 3'd3, 3'd0, 8'b0000_0100, 8'b0000_0100);
    @(negedge CLK);
    op_word   = make_move(1'b0, 3'd2, 3'd0, 8'b0001_0000, 8'b0001_0000);
    @(negedge CLK);
    op_strobe = 1'b0;
    op_word   = '0;
    repeat (2) @(negedge CLK);
    // the second move latches r2 at the edge that writes it, so it sees the old value
    model[4] = model[2];
    model[2] = model[3];
    check_all();
  endtask

  task automatic test_two_apart();
    send_op(make_move(1'b0, 3'd5, 3'd0, 8'b0000_0100, 8'b0000_0100));
    send_op(make_move(1'b0, 3'd2, 3'd0, 8'b0100_0000, 8'b0100_0000));
    repeat (2) @(negedge CLK);
    model[2] = model[5];
    model[6] = model[2];
    check_all();
  endtask

  task automatic test_load_collision();
    send_op(make_move(1'b0, 3'd7, 3'd0, 8'b0000_0001, 8'b0000_0001));
    // the load is sampled at the same edge as the crossbar write to r0
    @(negedge CLK);
    load_strobe = 1'b1;
    load_addr   = 3'd0;
    load_data   = lcg_next();
    @(negedge CLK);
    load_strobe = 1'b0;
    model[0]    = model[7];
    check_all();
  endtask

  initial
  begin
    CLK         = 1'b0;
    arst_n      = 1'b0;
    op_strobe   = 1'b0;
    op_word     = '0;
    load_strobe = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    rd_addr     = '0;
    lcg_state   = 32'h6374_dcc9;
    repeat (5) @(negedge CLK);
    arst_n = 1'b1;

    test_reset_values();
    test_loads();
    test_single_lane_fanout();
    test_dual_swap();
    test_literal();
    test_back_to_back();
    test_two_apart();
    test_load_collision();

    @(negedge CLK);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/xfer_pkg.sv
logic/xfer_decoder.sv
logic/xfer_crossbar.sv
logic/xfer_regfile.sv
logic/xfer_top.sv
verif/xfer_tb.sv
